// ==== logic/rv_alu_config.svh ====
`ifndef RV_ALU_CONFIG_SVH
`define RV_ALU_CONFIG_SVH

// datapath width of the integer unit
`define XLEN 64

// one iteration per operand bit in the muldiv units
`define MD_STEPS `XLEN

`endif

// ==== logic/rv_alu_pkg.sv ====
`include "rv_alu_config.svh"

package rv_alu_pkg;

    typedef logic [`XLEN-1:0] xlen_t;
    typedef logic [5:0]       shamt_t;

    // decoded basic ALU operation
    typedef struct packed {
        logic       word;
        logic       alt;
        logic [2:0] fn;
    } alu_ctrl_t;

    localparam logic [2:0] FN_ADD  = 3'b000;
    localparam logic [2:0] FN_SLL  = 3'b001;
    localparam logic [2:0] FN_SLT  = 3'b010;
    localparam logic [2:0] FN_SRC2 = 3'b011;
    localparam logic [2:0] FN_XOR  = 3'b100;
    localparam logic [2:0] FN_SR   = 3'b101;
    localparam logic [2:0] FN_OR   = 3'b110;
    localparam logic [2:0] FN_AND  = 3'b111;

    // decoded multiply/divide request
    typedef struct packed {
        logic       en;
        logic       is_div;
        logic [1:0] kind;
    } md_ctrl_t;

    // kind encodings, multiply side
    localparam logic [1:0] MD_MUL    = 2'b00;
    localparam logic [1:0] MD_MULH   = 2'b01;
    localparam logic [1:0] MD_MULHSU = 2'b10;
    localparam logic [1:0] MD_MULHU  = 2'b11;

    // kind encodings, divide side
    localparam logic [1:0] MD_DIV    = 2'b00;
    localparam logic [1:0] MD_DIVU   = 2'b01;
    localparam logic [1:0] MD_REM    = 2'b10;
    localparam logic [1:0] MD_REMU   = 2'b11;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } md_state_e;

endpackage

// ==== logic/alu_adder.sv ====
`timescale 1ns/1ps
`include "rv_alu_config.svh"

module alu_adder (
    input  rv_alu_pkg::xlen_t a_i,
    input  rv_alu_pkg::xlen_t b_i,
    input  logic              cin_i,
    input  logic              unsigned_i,
    output rv_alu_pkg::xlen_t sum_o,
    output logic              less_o,
    output logic              zero_o
);
    logic [`XLEN:0] sum_full;
    logic           carry;
    logic           overflow;

    assign sum_full = {1'b0, a_i} + {1'b0, b_i} + {{`XLEN{1'b0}}, cin_i};
    assign carry    = sum_full[`XLEN];
    assign sum_o    = sum_full[`XLEN-1:0];

    // same operand signs but the sum flips sign
    assign overflow = (a_i[`XLEN-1] == b_i[`XLEN-1]) && (sum_o[`XLEN-1] != a_i[`XLEN-1]);

    assign zero_o = ~|sum_o;

    // a - b borrows exactly when a < b unsigned
    assign less_o = unsigned_i ? ~carry : (sum_o[`XLEN-1] ^ overflow);

endmodule

// ==== logic/alu_shifter.sv ====
`timescale 1ns/1ps
`include "rv_alu_config.svh"

module alu_shifter (
    input  rv_alu_pkg::xlen_t   src_i,
    input  rv_alu_pkg::shamt_t  shamt_i,
    input  logic                word_i,
    input  logic                right_i,
    input  logic                arith_i,
    output rv_alu_pkg::xlen_t   shift_o
);
    import rv_alu_pkg::*;

    shamt_t amt;
    logic   sign;
    logic   fill;
    xlen_t  base;
    xlen_t  sh_in;
    xlen_t  sh_out;
    xlen_t  fill_mask;
    xlen_t  right_res;

    function automatic xlen_t bit_rev(input xlen_t v);
        xlen_t r;
        for (int i = 0; i < `XLEN; i++) begin
            r[i] = v[`XLEN-1-i];
        end
        return r;
    endfunction

    // word shifts only look at five bits of the amount
    assign amt  = word_i ? {1'b0, shamt_i[4:0]} : shamt_i;
    assign sign = word_i ? src_i[31] : src_i[`XLEN-1];
    assign fill = arith_i & right_i & sign;

    // sraw needs bit 31 to come in from above the low half
    assign base = word_i ? {{(`XLEN-32){fill}}, src_i[31:0]} : src_i;

    // left shift done as reverse, shift right, reverse
    assign sh_in  = right_i ? base : bit_rev(base);
    assign sh_out = sh_in >> amt;

    // ones in the top amt bits
    assign fill_mask = ~({`XLEN{1'b1}} >> amt);
    assign right_res = sh_out | (fill_mask & {`XLEN{fill}});

    assign shift_o = right_i ? right_res : bit_rev(sh_out);

endmodule

// ==== logic/seq_multiplier.sv ====
`timescale 1ns/1ps
`include "rv_alu_config.svh"

module seq_multiplier (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start_i,
    input  logic              flush_i,
    input  logic [1:0]        kind_i,
    input  logic              word_i,
    input  rv_alu_pkg::xlen_t a_i,
    input  rv_alu_pkg::xlen_t b_i,
    output rv_alu_pkg::xlen_t result_o,
    output logic              done_o
);
    import rv_alu_pkg::*;

    localparam int CW = $clog2(`MD_STEPS);

    md_state_e          state;
    logic [CW-1:0]      cnt;
    logic [1:0]         kind_q;
    logic               word_q;
    logic               neg_q;
    xlen_t              mcand_q;
    logic [2*`XLEN-1:0] acc_q;

    logic               a_signed;
    logic               b_signed;
    logic               a_neg;
    logic               b_neg;
    xlen_t              a_mag;
    xlen_t              b_mag;
    logic [`XLEN:0]     partial;
    logic [2*`XLEN-1:0] product;
    xlen_t              pick;

    // mulh: both signed, mulhsu: only a signed
    assign a_signed = (kind_i == MD_MULH) || (kind_i == MD_MULHSU);
    assign b_signed = (kind_i == MD_MULH);
    assign a_neg    = a_signed & a_i[`XLEN-1];
    assign b_neg    = b_signed & b_i[`XLEN-1];
    assign a_mag    = a_neg ? -a_i : a_i;
    assign b_mag    = b_neg ? -b_i : b_i;

    // add into the high half when the next multiplier bit is set
    assign partial = {1'b0, acc_q[2*`XLEN-1:`XLEN]} + (acc_q[0] ? {1'b0, mcand_q} : '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            cnt   <= '0;
        end else if (flush_i) begin
            state <= IDLE;
        end else if (start_i) begin
            state <= RUN;
            cnt   <= '0;
        end else if (state == RUN) begin
            cnt <= cnt + 1'b1;
            if (cnt == CW'(`MD_STEPS - 1)) begin
                state <= DONE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            kind_q  <= kind_i;
            word_q  <= word_i;
            neg_q   <= a_neg ^ b_neg;
            mcand_q <= a_mag;
            acc_q   <= {{`XLEN{1'b0}}, b_mag};
        end else if (state == RUN) begin
            acc_q <= {partial, acc_q[`XLEN-1:1]};
        end
    end

    assign product = neg_q ? -acc_q : acc_q;
    assign pick    = (kind_q == MD_MUL) ? product[`XLEN-1:0] : product[2*`XLEN-1:`XLEN];

    assign result_o = word_q ? {{(`XLEN-32){pick[31]}}, pick[31:0]} : pick;
    assign done_o   = (state == DONE);

endmodule

// ==== logic/seq_divider.sv ====
`timescale 1ns/1ps
`include "rv_alu_config.svh"

module seq_divider (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start_i,
    input  logic              flush_i,
    input  logic [1:0]        kind_i,
    input  logic              word_i,
    input  rv_alu_pkg::xlen_t a_i,
    input  rv_alu_pkg::xlen_t b_i,
    output rv_alu_pkg::xlen_t result_o,
    output logic              done_o
);
    import rv_alu_pkg::*;

    localparam int CW = $clog2(`MD_STEPS);

    md_state_e      state;
    logic [CW-1:0]  cnt;
    logic [1:0]     kind_q;
    logic           word_q;
    logic           q_neg_q;
    logic           r_neg_q;
    logic           div0_q;
    xlen_t          dvd_q;
    xlen_t          dsr_q;
    xlen_t          quo_q;
    xlen_t          rem_q;

    logic           is_signed;
    xlen_t          a_ext;
    xlen_t          b_ext;
    logic           a_neg;
    logic           b_neg;
    xlen_t          a_mag;
    xlen_t          b_mag;
    logic [`XLEN:0] rem_shift;
    logic [`XLEN:0] trial;
    xlen_t          quotient;
    xlen_t          remainder;
    xlen_t          pick;

    assign is_signed = (kind_i == MD_DIV) || (kind_i == MD_REM);

    // word ops: widen the low half, signed or unsigned by kind
    assign a_ext = word_i ? {{(`XLEN-32){is_signed & a_i[31]}}, a_i[31:0]} : a_i;
    assign b_ext = word_i ? {{(`XLEN-32){is_signed & b_i[31]}}, b_i[31:0]} : b_i;

    assign a_neg = is_signed & a_ext[`XLEN-1];
    assign b_neg = is_signed & b_ext[`XLEN-1];
    assign a_mag = a_neg ? -a_ext : a_ext;
    assign b_mag = b_neg ? -b_ext : b_ext;

    // restoring step, next dividend bit shifts in from quo_q
    assign rem_shift = {rem_q, quo_q[`XLEN-1]};
    assign trial     = rem_shift - {1'b0, dsr_q};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            cnt   <= '0;
        end else if (flush_i) begin
            state <= IDLE;
        end else if (start_i) begin
            state <= RUN;
            cnt   <= '0;
        end else if (state == RUN) begin
            cnt <= cnt + 1'b1;
            if (cnt == CW'(`MD_STEPS - 1)) begin
                state <= DONE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            kind_q  <= kind_i;
            word_q  <= word_i;
            q_neg_q <= a_neg ^ b_neg;
            r_neg_q <= a_neg;
            div0_q  <= (b_ext == '0);
            dvd_q   <= a_ext;
            dsr_q   <= b_mag;
            quo_q   <= a_mag;
            rem_q   <= '0;
        end else if (state == RUN) begin
            if (!trial[`XLEN]) begin
                rem_q <= trial[`XLEN-1:0];
                quo_q <= {quo_q[`XLEN-2:0], 1'b1};
            end else begin
                rem_q <= rem_shift[`XLEN-1:0];
                quo_q <= {quo_q[`XLEN-2:0], 1'b0};
            end
        end
    end

    // most negative / -1 needs nothing extra: the magnitude 2^63 fits
    // and both signs are negative, so the quotient comes back as the dividend
    assign quotient  = div0_q ? '1 : (q_neg_q ? -quo_q : quo_q);
    assign remainder = div0_q ? dvd_q : (r_neg_q ? -rem_q : rem_q);

    assign pick = ((kind_q == MD_REM) || (kind_q == MD_REMU)) ? remainder : quotient;

    assign result_o = word_q ? {{(`XLEN-32){pick[31]}}, pick[31:0]} : pick;
    assign done_o   = (state == DONE);

endmodule

// ==== logic/rv_alu.sv ====
`timescale 1ns/1ps
`include "rv_alu_config.svh"

module rv_alu (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rv_alu_pkg::alu_ctrl_t ctrl_i,
    input  rv_alu_pkg::md_ctrl_t  md_i,
    input  rv_alu_pkg::xlen_t     src1_i,
    input  rv_alu_pkg::xlen_t     src2_i,
    input  logic                  flush_i,
    output rv_alu_pkg::xlen_t     result_o,
    output logic                  less_o,
    output logic                  zero_o,
    output logic                  busy_o
);
    import rv_alu_pkg::*;

    logic     cin;
    xlen_t    add_b;
    xlen_t    sum;
    logic     less;
    xlen_t    shift;
    logic     shift_right;
    xlen_t    alu_res;
    xlen_t    raw_res;

    xlen_t    src1_q;
    xlen_t    src2_q;
    md_ctrl_t md_q;
    logic     word_q;
    logic     held_q;

    logic     req_diff;
    logic     md_start;
    logic     mul_start;
    logic     div_start;
    xlen_t    mul_res;
    xlen_t    div_res;
    logic     mul_done;
    logic     div_done;
    logic     sel_done;
    xlen_t    md_res;

    // subtract for sub and for the compares
    assign cin   = (ctrl_i.fn == FN_SLT) || ((ctrl_i.fn == FN_ADD) && ctrl_i.alt);
    assign add_b = src2_i ^ {`XLEN{cin}};

    assign shift_right = (ctrl_i.fn == FN_SR);

    alu_adder u_adder (
        .a_i        (src1_i),
        .b_i        (add_b),
        .cin_i      (cin),
        .unsigned_i (ctrl_i.alt),
        .sum_o      (sum),
        .less_o     (less),
        .zero_o     (zero_o)
    );

    alu_shifter u_shifter (
        .src_i   (src1_i),
        .shamt_i (src2_i[5:0]),
        .word_i  (ctrl_i.word),
        .right_i (shift_right),
        .arith_i (ctrl_i.alt),
        .shift_o (shift)
    );

    assign less_o = less;

    always_comb begin
        case (ctrl_i.fn)
            FN_ADD:        alu_res = sum;
            FN_SLL, FN_SR: alu_res = shift;
            FN_SLT:        alu_res = {{(`XLEN-1){1'b0}}, less};
            FN_SRC2:       alu_res = src2_i;
            FN_XOR:        alu_res = src1_i ^ src2_i;
            FN_OR:         alu_res = src1_i | src2_i;
            FN_AND:        alu_res = src1_i & src2_i;
            default:       alu_res = sum;
        endcase
    end

    // a new request is anything that differs from the latched one
    assign req_diff = (src1_i != src1_q) || (src2_i != src2_q) ||
                      (md_i != md_q) || (ctrl_i.word != word_q);

    assign md_start  = md_i.en && !flush_i && (req_diff || !held_q);
    assign mul_start = md_start && !md_i.is_div;
    assign div_start = md_start && md_i.is_div;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            src1_q <= '0;
            src2_q <= '0;
            md_q   <= '0;
            word_q <= 1'b0;
            held_q <= 1'b0;
        end else if (flush_i) begin
            held_q <= 1'b0;
        end else if (md_start) begin
            src1_q <= src1_i;
            src2_q <= src2_i;
            md_q   <= md_i;
            word_q <= ctrl_i.word;
            held_q <= 1'b1;
        end
    end

    seq_multiplier u_mul (
        .clk      (clk),
        .rst_n    (rst_n),
        .start_i  (mul_start),
        .flush_i  (flush_i),
        .kind_i   (md_i.kind),
        .word_i   (ctrl_i.word),
        .a_i      (src1_i),
        .b_i      (src2_i),
        .result_o (mul_res),
        .done_o   (mul_done)
    );

    seq_divider u_div (
        .clk      (clk),
        .rst_n    (rst_n),
        .start_i  (div_start),
        .flush_i  (flush_i),
        .kind_i   (md_i.kind),
        .word_i   (ctrl_i.word),
        .a_i      (src1_i),
        .b_i      (src2_i),
        .result_o (div_res),
        .done_o   (div_done)
    );

    // latched is_div matches the input whenever no start is pending
    assign sel_done = md_q.is_div ? div_done : mul_done;
    assign md_res   = md_q.is_div ? div_res : mul_res;

    assign busy_o = md_i.en && !flush_i && (md_start || !sel_done);

    assign raw_res  = md_i.en ? md_res : alu_res;
    assign result_o = ctrl_i.word ? {{(`XLEN-32){raw_res[31]}}, raw_res[31:0]} : raw_res;

endmodule

// ==== verification/clk_rst_gen.sv ====
`timescale 1ns/1ps

module clk_rst_gen #(
    parameter int PERIOD     = 10,
    parameter int RST_CYCLES = 8
) (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // reset released on a rising edge after a fixed count
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// ==== verification/rv_alu_tb.sv ====
`timescale 1ns/1ps
`include "rv_alu_config.svh"

module rv_alu_tb;
    import rv_alu_pkg::*;

    typedef struct packed {
        alu_ctrl_t ctrl;
        md_ctrl_t  md;
        xlen_t     src1;
        xlen_t     src2;
        xlen_t     exp_res;
    } vec_t;

    localparam int       ROUNDS = 4;
    localparam md_ctrl_t NO_MD  = '0;
    localparam xlen_t    MIN_S  = 64'h8000_0000_0000_0000;
    localparam xlen_t    SH_A   = 64'h8000_0000_8000_0001;
    localparam xlen_t    SH_W   = 64'hdead_beef_8000_0001;

    logic      clk;
    logic      rst_n;
    alu_ctrl_t ctrl;
    md_ctrl_t  md;
    xlen_t     src1;
    xlen_t     src2;
    logic      flush;
    xlen_t     result;
    logic      less;
    logic      zero;
    logic      busy;

    vec_t      vectors[$];
    vec_t      ops[$];
    int        cycles = 0;
    int        cycle_limit = 1000;
    int        busy_cycles = 0;

    clk_rst_gen u_clk_rst (
        .clk   (clk),
        .rst_n (rst_n)
    );

    rv_alu u_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .ctrl_i   (ctrl),
        .md_i     (md),
        .src1_i   (src1),
        .src2_i   (src2),
        .flush_i  (flush),
        .result_o (result),
        .less_o   (less),
        .zero_o   (zero),
        .busy_o   (busy)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("*** TEST FAILED ***");
            $fatal(1, "timeout: the run did not finish within %0d cycles", cycle_limit);
        end
    end

    function automatic alu_ctrl_t alu_op(input int word, input int alt, input logic [2:0] fn);
        return '{word: word[0], alt: alt[0], fn: fn};
    endfunction

    function automatic md_ctrl_t md_req(input int is_div, input logic [1:0] kind);
        return '{en: 1'b1, is_div: is_div[0], kind: kind};
    endfunction

    // behavioral model of the execute unit
    function automatic xlen_t ref_result(alu_ctrl_t c, md_ctrl_t m, xlen_t a, xlen_t b);
        logic [2*`XLEN-1:0] prod;
        logic [31:0]        w;
        logic               sgn;
        xlen_t              da;
        xlen_t              db;
        xlen_t              q;
        xlen_t              r;
        xlen_t              res;
        if (m.en && !m.is_div) begin
            // extend each operand by its own signedness
            prod = {{`XLEN{(m.kind == MD_MULH || m.kind == MD_MULHSU) & a[`XLEN-1]}}, a} *
                   {{`XLEN{(m.kind == MD_MULH) & b[`XLEN-1]}}, b};
            res = (m.kind == MD_MUL) ? prod[`XLEN-1:0] : prod[2*`XLEN-1:`XLEN];
        end else if (m.en) begin
            sgn = (m.kind == MD_DIV) || (m.kind == MD_REM);
            da  = c.word ? {{(`XLEN-32){sgn & a[31]}}, a[31:0]} : a;
            db  = c.word ? {{(`XLEN-32){sgn & b[31]}}, b[31:0]} : b;
            if (db == '0) begin
                q = '1;
                r = da;
            end else if (sgn && da == MIN_S && db == '1) begin
                q = da;
                r = '0;
            end else if (sgn) begin
                q = $signed(da) / $signed(db);
                r = $signed(da) % $signed(db);
            end else begin
                q = da / db;
                r = da % db;
            end
            res = (m.kind == MD_REM || m.kind == MD_REMU) ? r : q;
        end else begin
            case (c.fn)
                FN_ADD:  res = c.alt ? a - b : a + b;
                FN_SLL:  res = c.word ? a << b[4:0] : a << b[5:0];
                FN_SLT:  res = xlen_t'(c.alt ? (a < b) : ($signed(a) < $signed(b)));
                FN_SRC2: res = b;
                FN_XOR:  res = a ^ b;
                FN_OR:   res = a | b;
                FN_AND:  res = a & b;
                default: begin
                    if (c.word && c.alt) begin
                        w = $signed(a[31:0]) >>> b[4:0];
                    end else begin
                        w = a[31:0] >> b[4:0];
                    end
                    if (c.word) begin
                        res = {32'b0, w};
                    end else if (c.alt) begin
                        res = $signed(a) >>> b[5:0];
                    end else begin
                        res = a >> b[5:0];
                    end
                end
            endcase
        end
        // word results come back sign-extended from bit 31
        if (c.word) begin
            res = {{(`XLEN-32){res[31]}}, res[31:0]};
        end
        return res;
    endfunction

    task automatic check_value(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            $display("Error: %s = %h, expected %h (src1 %h, src2 %h)", name, got, exp,
                     src1, src2);
            $display("*** TEST FAILED ***");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic add_vec(input alu_ctrl_t c, input md_ctrl_t m, input xlen_t a,
                           input xlen_t b, input xlen_t e);
        vectors.push_back('{ctrl: c, md: m, src1: a, src2: b, exp_res: e});
    endtask

    task automatic run_vec(input vec_t v);
        xlen_t sum;
        @(posedge clk);
        ctrl  <= v.ctrl;
        md    <= v.md;
        src1  <= v.src1;
        src2  <= v.src2;
        flush <= 1'b0;
        @(negedge clk);
        if (v.md.en) begin
            check_value("busy_o", xlen_t'(busy), 64'h1);
            busy_cycles = 0;
            while (busy) begin
                busy_cycles++;
                @(negedge clk);
            end
        end else begin
            // adder subtracts for sub and both compares
            sum = (v.ctrl.fn == FN_SLT || (v.ctrl.fn == FN_ADD && v.ctrl.alt)) ?
                  v.src1 - v.src2 : v.src1 + v.src2;
            check_value("zero_o", xlen_t'(zero), xlen_t'(sum == '0));
            if (v.ctrl.fn == FN_SLT) begin
                check_value("less_o", xlen_t'(less), xlen_t'(v.exp_res[0]));
            end
        end
        check_value("result_o", result, v.exp_res);
    endtask

    task automatic build_vectors();
        add_vec(alu_op(0, 0, FN_ADD), NO_MD, '1, 64'h1, 64'h0);
        add_vec(alu_op(0, 1, FN_ADD), NO_MD, 64'h3, 64'ha, 64'hffff_ffff_ffff_fff9);
        add_vec(alu_op(1, 0, FN_ADD), NO_MD, 64'h7fff_ffff, 64'h1, 64'hffff_ffff_8000_0000);
        add_vec(alu_op(0, 0, FN_XOR), NO_MD, 64'hf0f0, 64'hff00, 64'h0ff0);
        add_vec(alu_op(0, 0, FN_OR), NO_MD, 64'hf0f0, 64'h0f00, 64'hfff0);
        add_vec(alu_op(0, 0, FN_AND), NO_MD, 64'hf0f0, 64'hff00, 64'hf000);
        add_vec(alu_op(0, 0, FN_SRC2), NO_MD, 64'h1, 64'hffff_ffff_8765_4000,
                64'hffff_ffff_8765_4000);
        // sign boundary for the compares
        add_vec(alu_op(0, 0, FN_SLT), NO_MD, MIN_S, 64'h1, 64'h1);
        add_vec(alu_op(0, 1, FN_SLT), NO_MD, MIN_S, 64'h1, 64'h0);
        add_vec(alu_op(0, 0, FN_SLT), NO_MD, 64'h1, MIN_S, 64'h0);
        add_vec(alu_op(0, 1, FN_SLT), NO_MD, 64'h1, MIN_S, 64'h1);
        // shifts at 0, 1, 31, 32 and 63
        add_vec(alu_op(0, 0, FN_SLL), NO_MD, SH_A, 64'd0, SH_A);
        add_vec(alu_op(0, 0, FN_SLL), NO_MD, SH_A, 64'd32, 64'h8000_0001_0000_0000);
        add_vec(alu_op(0, 0, FN_SLL), NO_MD, SH_A, 64'd63, 64'h8000_0000_0000_0000);
        add_vec(alu_op(0, 0, FN_SR), NO_MD, SH_A, 64'd1, 64'h4000_0000_4000_0000);
        add_vec(alu_op(0, 0, FN_SR), NO_MD, SH_A, 64'd31, 64'h0000_0001_0000_0001);
        add_vec(alu_op(0, 1, FN_SR), NO_MD, SH_A, 64'd32, 64'hffff_ffff_8000_0000);
        add_vec(alu_op(0, 1, FN_SR), NO_MD, SH_A, 64'd63, '1);
        add_vec(alu_op(1, 0, FN_SLL), NO_MD, SH_W, 64'd32, 64'hffff_ffff_8000_0001);
        add_vec(alu_op(1, 0, FN_SR), NO_MD, SH_W, 64'd31, 64'h1);
        add_vec(alu_op(1, 1, FN_SR), NO_MD, SH_W, 64'd1, 64'hffff_ffff_c000_0000);
        // multiply
        add_vec(alu_op(0, 0, FN_ADD), md_req(0, MD_MUL), '1, 64'h5, 64'hffff_ffff_ffff_fffb);
        add_vec(alu_op(0, 0, FN_ADD), md_req(0, MD_MULH), MIN_S, 64'h2, '1);
        add_vec(alu_op(0, 0, FN_ADD), md_req(0, MD_MULHSU), '1, '1, '1);
        add_vec(alu_op(0, 0, FN_ADD), md_req(0, MD_MULHU), '1, '1, 64'hffff_ffff_ffff_fffe);
        add_vec(alu_op(1, 0, FN_ADD), md_req(0, MD_MUL), 64'h0000_0003_0001_0000, 64'h8000,
                64'hffff_ffff_8000_0000);
        // divide with zero divisor and overflow cases
        add_vec(alu_op(0, 0, FN_ADD), md_req(1, MD_DIV), 64'd20, 64'hffff_ffff_ffff_fffd,
                64'hffff_ffff_ffff_fffa);
        add_vec(alu_op(0, 0, FN_ADD), md_req(1, MD_REM), 64'hffff_ffff_ffff_ffec, 64'h3,
                64'hffff_ffff_ffff_fffe);
        add_vec(alu_op(0, 0, FN_ADD), md_req(1, MD_DIV), 64'h1234, 64'h0, '1);
        add_vec(alu_op(0, 0, FN_ADD), md_req(1, MD_REMU), 64'h1234, 64'h0, 64'h1234);
        add_vec(alu_op(0, 0, FN_ADD), md_req(1, MD_DIV), MIN_S, '1, MIN_S);
        add_vec(alu_op(0, 0, FN_ADD), md_req(1, MD_REM), MIN_S, '1, 64'h0);
        add_vec(alu_op(1, 0, FN_ADD), md_req(1, MD_DIV), 64'h8000_0000, '1,
                64'hffff_ffff_8000_0000);
        add_vec(alu_op(1, 0, FN_ADD), md_req(1, MD_DIVU), 64'haaaa_aaaa_ffff_ffff, 64'h2,
                64'h7fff_ffff);
        add_vec(alu_op(1, 0, FN_ADD), md_req(1, MD_REMU), 64'h8000_0000, 64'h0,
                64'hffff_ffff_8000_0000);
        add_vec(alu_op(1, 0, FN_ADD), md_req(1, MD_REM), 64'h1234_5678_ffff_ffec, 64'h3,
                64'hffff_ffff_ffff_fffe);
    endtask

    // every legal opcode once with operands filled in later
    task automatic build_ops();
        vec_t v;
        v = '0;
        for (int f = 0; f < 8; f++) begin
            for (int alt = 0; alt < 2; alt++) begin
                v.ctrl = alu_op(0, alt, f[2:0]);
                v.md   = NO_MD;
                if (alt == 0 || v.ctrl.fn inside {FN_ADD, FN_SLT, FN_SR}) ops.push_back(v);
                v.ctrl.word = 1'b1;
                if (v.ctrl.fn inside {FN_ADD, FN_SR} || (v.ctrl.fn == FN_SLL && alt == 0)) begin
                    ops.push_back(v);
                end
            end
        end
        for (int k = 0; k < 4; k++) begin
            v.ctrl = alu_op(0, 0, FN_ADD);
            v.md   = md_req(0, k[1:0]);
            ops.push_back(v);
            v.md = md_req(1, k[1:0]);
            ops.push_back(v);
            v.ctrl.word = 1'b1;
            ops.push_back(v);
        end
        // mulw is the only word multiply
        v.md = md_req(0, MD_MUL);
        ops.push_back(v);
    endtask

    initial begin
        vec_t v;
        ctrl  = '0;
        md    = '0;
        src1  = '0;
        src2  = '0;
        flush = 1'b0;
        void'($urandom(32'h24aba197));
        build_vectors();
        build_ops();
        cycle_limit = (vectors.size() + ROUNDS * ops.size() + 3) * (`MD_STEPS + 10);
        wait (rst_n);

        foreach (vectors[i]) run_vec(vectors[i]);

        for (int r = 0; r < ROUNDS; r++) begin
            foreach (ops[i]) begin
                v         = ops[i];
                v.src1    = {$urandom, $urandom};
                v.src2    = {$urandom, $urandom} >> ($urandom % 64);
                v.exp_res = ref_result(v.ctrl, v.md, v.src1, v.src2);
                run_vec(v);
            end
        end

        // abort a running divide and present the same request again
        v.ctrl    = alu_op(0, 0, FN_ADD);
        v.md      = md_req(1, MD_DIVU);
        v.src1    = 64'd1000000;
        v.src2    = 64'd7;
        v.exp_res = ref_result(v.ctrl, v.md, v.src1, v.src2);
        @(posedge clk);
        ctrl <= v.ctrl;
        md   <= v.md;
        src1 <= v.src1;
        src2 <= v.src2;
        repeat (4) @(negedge clk);
        check_value("busy_o", xlen_t'(busy), 64'h1);
        @(posedge clk);
        flush <= 1'b1;
        @(negedge clk);
        check_value("busy_o", xlen_t'(busy), 64'h0);
        run_vec(v);
        // a fresh start runs every iteration again
        check_value("busy_o full run after flush", xlen_t'(busy_cycles >= `MD_STEPS), 64'h1);

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+logic
logic/rv_alu_pkg.sv
logic/alu_adder.sv
logic/alu_shifter.sv
logic/seq_multiplier.sv
logic/seq_divider.sv
logic/rv_alu.sv
verification/clk_rst_gen.sv
verification/rv_alu_tb.sv

// ==== Makefile ====
TOP := rv_alu_tb

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f sim.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
